//--- dotp_unit.f
+incdir+tests
hdl/fp_fmt_pkg.sv
hdl/dotp_op_pkg.sv
hdl/dotp_csr.sv
hdl/dotp_operand_unpack.sv
hdl/dotp_multi_add.sv
hdl/dotp_unit_top.sv
tests/tb_dotp_unit.sv

//--- hdl/dotp_csr.sv
// rounding mode and sticky flags; a flag write in the same cycle as a flag update keeps both
`timescale 1ns/1ps
`default_nettype none

module dotp_csr (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // register access, reads are combinational
  input  logic                     csr_we_i,
  input  dotp_op_pkg::csr_addr_e   csr_addr_i,
  input  logic [3:0]               csr_wdata_i,
  output logic [3:0]               csr_rdata_o,
  // datapath side
  output dotp_op_pkg::round_mode_e frm_o,
  input  logic                     flags_valid_i,
  input  logic [3:0]               flags_i
);

  dotp_op_pkg::round_mode_e frm_q;      // current rounding mode
  logic [3:0]               fflags_q;   // accumulated NV OF UF NX
  logic [3:0]               new_flags;  // flags retiring this cycle

  assign new_flags = flags_valid_i ? flags_i : 4'b0000;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      frm_q    <= dotp_op_pkg::RNE;
      fflags_q <= '0;
    end else begin
      if (csr_we_i && csr_addr_i == dotp_op_pkg::CSR_FRM) begin
        frm_q <= dotp_op_pkg::round_mode_e'(csr_wdata_i[1:0]);  // upper bits dropped
      end
      // a write replaces, but never loses a result retiring right now
      if (csr_we_i && csr_addr_i == dotp_op_pkg::CSR_FFLAGS) begin
        fflags_q <= csr_wdata_i | new_flags;
      end else begin
        fflags_q <= fflags_q | new_flags;  // sticky
      end
    end
  end

  assign frm_o = frm_q;  // ops sample this in their issue cycle

  // read mux
  assign csr_rdata_o = (csr_addr_i == dotp_op_pkg::CSR_FRM) ? {2'b00, frm_q} : fflags_q;

  // --------------------
  // checks
  // --------------------
  // a write strobe out of reset must carry a real address, or frm goes astray
  csr_addr_known_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_we_i |-> !$isunknown(csr_addr_i));

endmodule

`default_nettype wire

//--- hdl/dotp_multi_add.sv
// exact fixed-point sum with one rounding; FP16 subnormal results flush to zero with UF and NX
`timescale 1ns/1ps
`default_nettype none

module dotp_multi_add #(
  parameter int unsigned NUM_PIPE_REGS = 1,  // extra stages behind the input register, 0 to 2
  parameter int unsigned TAG_WIDTH     = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     in_valid_i,
  input  logic [7:0]               src_a_i,
  input  logic [7:0]               src_b_i,
  input  logic [7:0]               src_c_i,
  input  logic [7:0]               src_d_i,
  input  logic [15:0]              addend_i,
  input  logic [2:0]               nan_boxed_ok_i,
  input  dotp_op_pkg::round_mode_e frm_i,
  input  logic [TAG_WIDTH-1:0]     tag_i,
  output logic                     out_valid_o,
  output logic [15:0]              result_o,
  output logic [3:0]               status_o,
  output logic [TAG_WIDTH-1:0]     tag_o
);

  // --------------------
  // grid constants
  // --------------------
  localparam int unsigned E8  = fp_fmt_pkg::FP8_EXP_BITS;
  localparam int unsigned M8  = fp_fmt_pkg::FP8_MAN_BITS;
  localparam int unsigned E16 = fp_fmt_pkg::FP16_EXP_BITS;
  localparam int unsigned M16 = fp_fmt_pkg::FP16_MAN_BITS;

  localparam int unsigned MAG_W    = 67;  // largest sum is below 2^65 grid units
  // grid lsb is the smallest subnormal product, 2^-32
  localparam int unsigned GRID_LSB = 2 * (fp_fmt_pkg::FP8_BIAS - 1 + M8);
  localparam int unsigned P_OFS    = 2 * (fp_fmt_pkg::FP8_BIAS + M8) - GRID_LSB;
  localparam int unsigned E_OFS    = GRID_LSB - fp_fmt_pkg::FP16_BIAS - M16;
  localparam int unsigned NORM_OFS = GRID_LSB - fp_fmt_pkg::FP16_BIAS;  // lead pos to biased exp

  // --------------------
  // input register
  // --------------------
  logic                     in_valid_q;
  logic [7:0]               lane_q [4];  // a b c d
  logic [15:0]              e_q;
  logic [2:0]               boxed_q;
  dotp_op_pkg::round_mode_e frm_q;       // mode travels with its op
  logic [TAG_WIDTH-1:0]     tag_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    lane_q[0] <= src_a_i;
    lane_q[1] <= src_b_i;
    lane_q[2] <= src_c_i;
    lane_q[3] <= src_d_i;
    e_q       <= addend_i;
    boxed_q   <= nan_boxed_ok_i;
    frm_q     <= frm_i;
    tag_q     <= tag_i;
  end

  // --------------------
  // operand decode
  // --------------------
  logic       l_sgn  [4];
  logic [2:0] l_sig  [4];  // hidden bit and mantissa
  logic [4:0] l_exp  [4];  // subnormals read as exponent 1
  logic       l_zero [4];
  logic       l_inf  [4];
  logic       l_nan  [4];

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      l_sgn[i]  = lane_q[i][M8+E8];
      l_sig[i]  = {|lane_q[i][M8 +: E8], lane_q[i][M8-1:0]};
      l_exp[i]  = (lane_q[i][M8 +: E8] == '0) ? 5'd1 : lane_q[i][M8 +: E8];
      l_zero[i] = boxed_q[i % 2] & (lane_q[i][M8+E8-1:0] == '0);
      l_inf[i]  = boxed_q[i % 2] & (&lane_q[i][M8 +: E8]) & (lane_q[i][M8-1:0] == '0);
      l_nan[i]  = ~boxed_q[i % 2] | ((&lane_q[i][M8 +: E8]) & (lane_q[i][M8-1:0] != '0));
    end
  end

  logic        e_sgn, e_zero, e_inf, e_nan;
  logic [10:0] e_sig;
  logic [4:0]  e_exp;

  assign e_sgn  = e_q[M16+E16];
  assign e_sig  = {|e_q[M16 +: E16], e_q[M16-1:0]};
  assign e_exp  = (e_q[M16 +: E16] == '0) ? 5'd1 : e_q[M16 +: E16];
  assign e_zero = boxed_q[2] & (e_q[M16+E16-1:0] == '0);
  assign e_inf  = boxed_q[2] & (&e_q[M16 +: E16]) & (e_q[M16-1:0] == '0);
  assign e_nan  = ~boxed_q[2] | ((&e_q[M16 +: E16]) & (e_q[M16-1:0] != '0));

  // --------------------
  // special cases
  // --------------------
  logic sgn_ab, sgn_cd, inv_ab, inv_cd, any_nan, pos_inf, neg_inf, invalid;

  assign sgn_ab  = l_sgn[0] ^ l_sgn[1];
  assign sgn_cd  = l_sgn[2] ^ l_sgn[3];
  assign inv_ab  = (l_inf[0] & l_zero[1]) | (l_zero[0] & l_inf[1]);  // inf * 0
  assign inv_cd  = (l_inf[2] & l_zero[3]) | (l_zero[2] & l_inf[3]);
  assign any_nan = l_nan[0] | l_nan[1] | l_nan[2] | l_nan[3] | e_nan;
  assign pos_inf = ((l_inf[0] | l_inf[1]) & ~sgn_ab) | ((l_inf[2] | l_inf[3]) & ~sgn_cd)
                 | (e_inf & ~e_sgn);
  assign neg_inf = ((l_inf[0] | l_inf[1]) & sgn_ab) | ((l_inf[2] | l_inf[3]) & sgn_cd)
                 | (e_inf & e_sgn);
  assign invalid = inv_ab | inv_cd | (pos_inf & neg_inf & ~any_nan);  // inf - inf

  // --------------------
  // exact products and alignment
  // --------------------
  logic [5:0]            prod_ab, prod_cd;  // exact 3x3 bit products
  logic [5:0]            shf_ab, shf_cd, shf_e;
  logic [MAG_W-1:0]      mag_ab, mag_cd, mag_e;
  logic signed [MAG_W:0] t_ab, t_cd, t_e, acc, acc_abs;
  logic                  sum_neg;
  logic [MAG_W-1:0]      sum_mag;

  assign prod_ab = l_sig[0] * l_sig[1];
  assign prod_cd = l_sig[2] * l_sig[3];
  assign shf_ab  = 6'(l_exp[0] + l_exp[1] - P_OFS);  // grid position of product lsb
  assign shf_cd  = 6'(l_exp[2] + l_exp[3] - P_OFS);
  assign shf_e   = 6'(e_exp + E_OFS);
  assign mag_ab  = MAG_W'(prod_ab) << shf_ab;
  assign mag_cd  = MAG_W'(prod_cd) << shf_cd;
  assign mag_e   = MAG_W'(e_sig) << shf_e;

  assign t_ab = sgn_ab ? -$signed({1'b0, mag_ab}) : $signed({1'b0, mag_ab});
  assign t_cd = sgn_cd ? -$signed({1'b0, mag_cd}) : $signed({1'b0, mag_cd});
  assign t_e  = e_sgn ? -$signed({1'b0, mag_e}) : $signed({1'b0, mag_e});

  assign acc     = t_ab + t_cd + t_e;  // exact, no bits lost
  assign sum_neg = acc[MAG_W];
  assign acc_abs = sum_neg ? -acc : acc;
  assign sum_mag = acc_abs[MAG_W-1:0];

  // --------------------
  // normalize and round
  // --------------------
  logic [6:0]       lead;     // position of leading one
  logic [MAG_W-1:0] norm;     // leading one moved to the top bit
  logic [M16-1:0]   rnd_man;
  logic             rnd_bit, sticky, rnd_up, ovf_inf, zero_sign;
  logic [16:0]      rounded;  // {exp, man}, mantissa carry spills into exp

  always_comb begin
    lead = '0;
    for (int i = 0; i < MAG_W; i++) begin
      if (sum_mag[i]) begin
        lead = 7'(i);
      end
    end
    norm    = sum_mag << (7'(MAG_W - 1) - lead);
    rnd_man = norm[MAG_W-2 -: M16];
    rnd_bit = norm[MAG_W-2-M16];
    sticky  = |norm[MAG_W-3-M16:0];
    rnd_up  = 1'b0;  // RTZ truncates
    case (frm_q)
      dotp_op_pkg::RNE: rnd_up = rnd_bit & (sticky | rnd_man[0]);
      dotp_op_pkg::RDN: rnd_up = (rnd_bit | sticky) & sum_neg;
      dotp_op_pkg::RUP: rnd_up = (rnd_bit | sticky) & ~sum_neg;
      default:          rnd_up = 1'b0;
    endcase
    rounded = {7'(lead - NORM_OFS), rnd_man} + 17'(rnd_up);
  end

  // overflow goes to inf unless the mode rounds toward zero on that side
  assign ovf_inf = (frm_q == dotp_op_pkg::RNE) | ((frm_q == dotp_op_pkg::RDN) & sum_neg)
                 | ((frm_q == dotp_op_pkg::RUP) & ~sum_neg);

  // exact zero: -0 only for all negative zeros, or under RDN
  assign zero_sign = (l_zero[0] | l_zero[1]) & (l_zero[2] | l_zero[3]) & e_zero
                   ? ((sgn_ab & sgn_cd & e_sgn)
                      | ((sgn_ab | sgn_cd | e_sgn) & (frm_q == dotp_op_pkg::RDN)))
                   : (frm_q == dotp_op_pkg::RDN);

  // --------------------
  // result select
  // --------------------
  logic [15:0]            res_d;
  fp_fmt_pkg::status_bits status_d;

  always_comb begin
    res_d    = '0;
    status_d = '0;
    if (invalid) begin
      res_d                      = fp_fmt_pkg::FP16_QNAN;
      status_d[fp_fmt_pkg::ST_NV] = 1'b1;
    end else if (any_nan) begin
      res_d = fp_fmt_pkg::FP16_QNAN;  // quiet, unboxed words land here too
    end else if (pos_inf | neg_inf) begin
      res_d = {neg_inf, {E16{1'b1}}, {M16{1'b0}}};
    end else if (sum_mag == '0) begin
      res_d = {zero_sign, 15'h0000};
    end else if (lead <= NORM_OFS) begin
      res_d                       = {sum_neg, 15'h0000};  // below min normal, flush
      status_d[fp_fmt_pkg::ST_UF] = 1'b1;
      status_d[fp_fmt_pkg::ST_NX] = 1'b1;
    end else if (rounded[16:M16] >= 7'd31) begin
      res_d = ovf_inf ? {sum_neg, {E16{1'b1}}, {M16{1'b0}}}
                      : {sum_neg, 5'h1E, {M16{1'b1}}};      // largest finite
      status_d[fp_fmt_pkg::ST_OF] = 1'b1;
      status_d[fp_fmt_pkg::ST_NX] = 1'b1;
    end else begin
      res_d                       = {sum_neg, rounded[14:0]};
      status_d[fp_fmt_pkg::ST_NX] = rnd_bit | sticky;
    end
  end

  // --------------------
  // output pipeline
  // --------------------
  logic                 valid_pipe [NUM_PIPE_REGS+1];
  logic [15:0]          res_pipe   [NUM_PIPE_REGS+1];
  logic [3:0]           st_pipe    [NUM_PIPE_REGS+1];
  logic [TAG_WIDTH-1:0] tag_pipe   [NUM_PIPE_REGS+1];

  assign valid_pipe[0] = in_valid_q;  // stage 0 is the combinational result
  assign res_pipe[0]   = res_d;
  assign st_pipe[0]    = status_d;
  assign tag_pipe[0]   = tag_q;

  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_pipe
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_pipe[i+1] <= 1'b0;
      end else begin
        valid_pipe[i+1] <= valid_pipe[i];
      end
    end

    always_ff @(posedge clk_i) begin
      res_pipe[i+1] <= res_pipe[i];
      st_pipe[i+1]  <= st_pipe[i];
      tag_pipe[i+1] <= tag_pipe[i];
    end
  end

  assign out_valid_o = valid_pipe[NUM_PIPE_REGS];
  assign result_o    = res_pipe[NUM_PIPE_REGS];
  assign status_o    = st_pipe[NUM_PIPE_REGS];
  assign tag_o       = tag_pipe[NUM_PIPE_REGS];

  // valid reaches the flag register too, an X here would poison fflags
  out_valid_known_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(out_valid_o));

endmodule

`default_nettype wire

//--- hdl/dotp_op_pkg.sv
// opcode and rounding encodings for the dot-product unit; RMM is not supported
`default_nettype none

package dotp_op_pkg;

  // operations
  typedef enum logic {
    SDOTP = 1'b0,  // a*b + c*d + e
    VSUM  = 1'b1   // a + c + e, second source ignored
  } dotp_op_e;

  // rounding modes, low bits of the risc-v frm encoding
  typedef enum logic [1:0] {
    RNE = 2'b00,  // nearest, ties to even
    RTZ = 2'b01,  // toward zero
    RDN = 2'b10,  // toward -inf
    RUP = 2'b11   // toward +inf
  } round_mode_e;

  // config registers
  typedef enum logic {
    CSR_FFLAGS = 1'b0,
    CSR_FRM    = 1'b1
  } csr_addr_e;

endpackage

`default_nettype wire

//--- hdl/dotp_operand_unpack.sv
// FP8 pairs sit in the low half of each word; the upper half must be all ones or it reads as NaN
`timescale 1ns/1ps
`default_nettype none

module dotp_operand_unpack (
  input  dotp_op_pkg::dotp_op_e               op_i,
  input  logic [fp_fmt_pkg::REG_WIDTH-1:0]    operand_a_i,  // {box, c, a}
  input  logic [fp_fmt_pkg::REG_WIDTH-1:0]    operand_b_i,  // {box, d, b}
  input  logic [fp_fmt_pkg::REG_WIDTH-1:0]    operand_c_i,  // {box, e}
  output logic [7:0]                          src_a_o,
  output logic [7:0]                          src_b_o,
  output logic [7:0]                          src_c_o,
  output logic [7:0]                          src_d_o,
  output logic [15:0]                         addend_o,
  output logic [2:0]                          nan_boxed_ok_o  // one bit per source word
);

  // --------------------
  // constants
  // --------------------
  localparam int unsigned HALF = fp_fmt_pkg::REG_WIDTH / 2;  // boxed payload width

  // E5M2 +1.0, biased exponent with empty mantissa
  localparam logic [7:0] FP8_ONE = {1'b0, fp_fmt_pkg::FP8_EXP_BITS'(fp_fmt_pkg::FP8_BIAS),
                                    {fp_fmt_pkg::FP8_MAN_BITS{1'b0}}};

  logic is_vsum;

  assign is_vsum = (op_i == dotp_op_pkg::VSUM);

  // --------------------
  // boxing checks
  // --------------------
  always_comb begin
    nan_boxed_ok_o[0] = &operand_a_i[fp_fmt_pkg::REG_WIDTH-1:HALF];
    // second word ignored on vsum so it can never poison the sum
    nan_boxed_ok_o[1] = is_vsum | (&operand_b_i[fp_fmt_pkg::REG_WIDTH-1:HALF]);
    nan_boxed_ok_o[2] = &operand_c_i[fp_fmt_pkg::REG_WIDTH-1:HALF];
  end

  // --------------------
  // lane select
  // --------------------
  always_comb begin
    src_a_o  = operand_a_i[7:0];    // low lane
    src_c_o  = operand_a_i[15:8];   // high lane of the low half
    addend_o = operand_c_i[HALF-1:0];
    if (is_vsum) begin
      // multiply by one keeps a single sum-of-products datapath
      src_b_o = FP8_ONE;
      src_d_o = FP8_ONE;
    end else begin
      src_b_o = operand_b_i[7:0];
      src_d_o = operand_b_i[15:8];
    end
  end

endmodule

`default_nettype wire

//--- hdl/dotp_unit_top.sv
// one op per cycle, no ready; results appear 1 + NUM_PIPE_REGS cycles after issue for one cycle
`timescale 1ns/1ps
`default_nettype none

module dotp_unit_top #(
  parameter int unsigned NUM_PIPE_REGS = 1,
  parameter int unsigned TAG_WIDTH     = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // issue side
  input  logic                               op_valid_i,
  input  dotp_op_pkg::dotp_op_e              op_i,
  input  logic [fp_fmt_pkg::REG_WIDTH-1:0]   operand_a_i,
  input  logic [fp_fmt_pkg::REG_WIDTH-1:0]   operand_b_i,
  input  logic [fp_fmt_pkg::REG_WIDTH-1:0]   operand_c_i,
  input  logic [TAG_WIDTH-1:0]               tag_i,
  // config access
  input  logic                               csr_we_i,
  input  dotp_op_pkg::csr_addr_e             csr_addr_i,
  input  logic [3:0]                         csr_wdata_i,
  output logic [3:0]                         csr_rdata_o,
  // result side
  output logic                               res_valid_o,
  output logic [fp_fmt_pkg::REG_WIDTH-1:0]   result_o,  // nan-boxed half
  output logic [3:0]                         status_o,
  output logic [TAG_WIDTH-1:0]               tag_o
);

  logic [7:0]               src_a, src_b, src_c, src_d;  // fp8 lanes
  logic [15:0]              addend;
  logic [2:0]               boxed_ok;
  dotp_op_pkg::round_mode_e frm;
  logic [15:0]              res_half;

  dotp_operand_unpack dotp_operand_unpack_inst (
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .operand_c_i    (operand_c_i),
    .src_a_o        (src_a),
    .src_b_o        (src_b),
    .src_c_o        (src_c),
    .src_d_o        (src_d),
    .addend_o       (addend),
    .nan_boxed_ok_o (boxed_ok)
  );

  dotp_multi_add #(
    .NUM_PIPE_REGS (NUM_PIPE_REGS),
    .TAG_WIDTH     (TAG_WIDTH)
  ) dotp_multi_add_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (op_valid_i),
    .src_a_i        (src_a),
    .src_b_i        (src_b),
    .src_c_i        (src_c),
    .src_d_i        (src_d),
    .addend_i       (addend),
    .nan_boxed_ok_i (boxed_ok),
    .frm_i          (frm),  // sampled with the op
    .tag_i          (tag_i),
    .out_valid_o    (res_valid_o),
    .result_o       (res_half),
    .status_o       (status_o),
    .tag_o          (tag_o)
  );

  // flags retire together with the result
  dotp_csr dotp_csr_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o),
    .frm_o         (frm),
    .flags_valid_i (res_valid_o),
    .flags_i       (status_o)
  );

  assign result_o = {16'hFFFF, res_half};  // box the half into the register word

endmodule

`default_nettype wire

//--- hdl/fp_fmt_pkg.sv
// fixed E5M2 sources and IEEE half results only; no alternate formats, no runtime format select
`default_nettype none

package fp_fmt_pkg;

  // --------------------
  // register words
  // --------------------
  localparam int unsigned REG_WIDTH = 32;  // one fp register, narrow values nan-boxed inside

  // --------------------
  // E5M2 source lanes
  // --------------------
  localparam int unsigned FP8_EXP_BITS = 5;
  localparam int unsigned FP8_MAN_BITS = 2;   // hidden bit not counted
  localparam int unsigned FP8_BIAS     = 15;

  // --------------------
  // FP16 addend and result
  // --------------------
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;
  localparam int unsigned FP16_BIAS     = 15;

  // canonical quiet nan, positive, msb of mantissa set
  localparam logic [15:0] FP16_QNAN = 16'h7E00;

  // status vector, NV in the top bit like fflags
  typedef logic [3:0] status_bits;

  localparam int unsigned ST_NV = 3;  // invalid
  localparam int unsigned ST_OF = 2;  // overflow
  localparam int unsigned ST_UF = 1;  // underflow
  localparam int unsigned ST_NX = 0;  // inexact

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the dot-product testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dotp_unit \
  -f dotp_unit.f \
  -o tb_dotp_unit

./obj_dir/tb_dotp_unit | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run_sim: pass found in sim.log"
else
  echo "run_sim: no pass in sim.log"
  exit 1
fi

//--- tests/dotp_vectors.svh
// rows run in issue order and are grouped by rounding mode; every frm change costs one CSR write

  // columns: op, word a {box, c, a}, word b {box, d, b}, word c {box, e}, frm,
  // expected half result, expected status NV OF UF NX
  task automatic load_vectors();
    // --------------------
    // exact sums, RNE
    // --------------------
    add_vector(OP_DOT, 32'hFFFF3C3C, 32'hFFFF3C3C, 32'hFFFF3C00, M_RNE, 16'h4200, 4'b0000);
    add_vector(OP_DOT, 32'hFFFF4240, 32'hFFFFBC3E, 32'hFFFF3800, M_RNE, 16'h3800, 4'b0000);
    add_vector(OP_DOT, 32'hFFFF003D, 32'hFFFF003F, 32'hFFFF0000, M_RNE, 16'h4060, 4'b0000);
    // fp8 subnormal 0.75*2^-14 times 16
    add_vector(OP_DOT, 32'hFFFF0003, 32'hFFFF004C, 32'hFFFF0000, M_RNE, 16'h1200, 4'b0000);
    // vsum, word b unboxed on purpose
    add_vector(OP_SUM, 32'hFFFF3E40, 32'h12345678, 32'hFFFF3C00, M_RNE, 16'h4480, 4'b0000);
    add_vector(OP_SUM, 32'hFFFFBEC0, 32'hFFFF3C3C, 32'hFFFF3800, M_RNE, 16'hC200, 4'b0000);
    // 1 + 0.75 ulp, then 1 + 1.5 ulp as a tie to even
    add_vector(OP_DOT, 32'hFFFF0012, 32'hFFFF003C, 32'hFFFF3C00, M_RNE, 16'h3C01, 4'b0001);
    add_vector(OP_DOT, 32'hFFFF0010, 32'hFFFF003C, 32'hFFFF3C01, M_RNE, 16'h3C02, 4'b0001);
    // 2^-16 is below the fp16 normal range
    add_vector(OP_DOT, 32'hFFFF0001, 32'hFFFF003C, 32'hFFFF0000, M_RNE, 16'h0000, 4'b0011);
    add_vector(OP_DOT, 32'hFFFF0081, 32'hFFFF003C, 32'hFFFF0000, M_RNE, 16'h8000, 4'b0011);
    add_vector(OP_DOT, 32'hFFFF007B, 32'hFFFF003C, 32'hFFFF7BFF, M_RNE, 16'h7C00, 4'b0101);
    // specials: inf*0, unboxed a, inf-inf, plain inf
    add_vector(OP_DOT, 32'hFFFF007C, 32'hFFFF0000, 32'hFFFF0000, M_RNE, 16'h7E00, 4'b1000);
    add_vector(OP_DOT, 32'h00003C3C, 32'hFFFF3C3C, 32'hFFFF3C00, M_RNE, 16'h7E00, 4'b0000);
    add_vector(OP_DOT, 32'hFFFF7C7C, 32'hFFFFBC3C, 32'hFFFF0000, M_RNE, 16'h7E00, 4'b1000);
    add_vector(OP_DOT, 32'hFFFF007C, 32'hFFFF003C, 32'hFFFF3C00, M_RNE, 16'h7C00, 4'b0000);
    add_vector(OP_DOT, 32'hFFFFBC3C, 32'hFFFF3C3C, 32'hFFFF0000, M_RNE, 16'h0000, 4'b0000);
    add_vector(OP_SUM, 32'hFFFF3C3C, 32'hFFFF3C3C, 32'h00003C00, M_RNE, 16'h7E00, 4'b0000);
    // --------------------
    // directed modes
    // --------------------
    add_vector(OP_DOT, 32'hFFFF0012, 32'hFFFF003C, 32'hFFFF3C00, M_RTZ, 16'h3C00, 4'b0001);
    add_vector(OP_DOT, 32'hFFFF007B, 32'hFFFF003C, 32'hFFFF7BFF, M_RTZ, 16'h7BFF, 4'b0101);
    add_vector(OP_DOT, 32'hFFFF0092, 32'hFFFF003C, 32'hFFFFBC00, M_RTZ, 16'hBC00, 4'b0001);
    add_vector(OP_DOT, 32'hFFFF0012, 32'hFFFF003C, 32'hFFFF3C00, M_RDN, 16'h3C00, 4'b0001);
    add_vector(OP_DOT, 32'hFFFF0092, 32'hFFFF003C, 32'hFFFFBC00, M_RDN, 16'hBC01, 4'b0001);
    // x - x is -0 only toward -inf
    add_vector(OP_DOT, 32'hFFFFBC3C, 32'hFFFF3C3C, 32'hFFFF0000, M_RDN, 16'h8000, 4'b0000);
    add_vector(OP_DOT, 32'hFFFF00FB, 32'hFFFF003C, 32'hFFFFFBFF, M_RDN, 16'hFC00, 4'b0101);
    add_vector(OP_DOT, 32'hFFFF0012, 32'hFFFF003C, 32'hFFFF3C00, M_RUP, 16'h3C01, 4'b0001);
    add_vector(OP_DOT, 32'hFFFF0092, 32'hFFFF003C, 32'hFFFFBC00, M_RUP, 16'hBC00, 4'b0001);
    add_vector(OP_DOT, 32'hFFFF00FB, 32'hFFFF003C, 32'hFFFFFBFF, M_RUP, 16'hFBFF, 4'b0101);
    add_vector(OP_DOT, 32'hFFFF0001, 32'hFFFF003C, 32'hFFFF0000, M_RUP, 16'h0000, 4'b0011);
  endtask

//--- tests/tb_dotp_unit.sv
// runs the default NUM_PIPE_REGS = 1 build; results are sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_dotp_unit;

  localparam int unsigned NUM_PIPE_REGS = 1;
  localparam int unsigned TAG_WIDTH     = 8;
  localparam int unsigned LATENCY       = 1 + NUM_PIPE_REGS;  // from the issue edge
  localparam int unsigned RESET_CYCLES  = 8;
  localparam int unsigned CLK_PERIOD    = 20;

  // short names for the table rows
  localparam dotp_op_pkg::dotp_op_e    OP_DOT = dotp_op_pkg::SDOTP;
  localparam dotp_op_pkg::dotp_op_e    OP_SUM = dotp_op_pkg::VSUM;
  localparam dotp_op_pkg::round_mode_e M_RNE  = dotp_op_pkg::RNE;
  localparam dotp_op_pkg::round_mode_e M_RTZ  = dotp_op_pkg::RTZ;
  localparam dotp_op_pkg::round_mode_e M_RDN  = dotp_op_pkg::RDN;
  localparam dotp_op_pkg::round_mode_e M_RUP  = dotp_op_pkg::RUP;

  logic                   clk, rst_n;
  logic                   op_valid;
  dotp_op_pkg::dotp_op_e  op;
  logic [31:0]            operand_a, operand_b, operand_c;
  logic [TAG_WIDTH-1:0]   tag_in, tag_out;
  logic                   csr_we;
  dotp_op_pkg::csr_addr_e csr_addr;
  logic [3:0]             csr_wdata, csr_rdata;
  logic                   res_valid;
  logic [31:0]            result;
  logic [3:0]             status;

  // stimulus table, filled by load_vectors
  dotp_op_pkg::dotp_op_e    vec_op   [$];
  logic [31:0]              vec_a    [$];
  logic [31:0]              vec_b    [$];
  logic [31:0]              vec_c    [$];
  dotp_op_pkg::round_mode_e vec_mode [$];
  logic [15:0]              vec_res  [$];
  logic [3:0]               vec_st   [$];

  int unsigned issue_edge [2**TAG_WIDTH];  // edge number that issued each tag
  int unsigned cyc       = 0;
  int unsigned errors    = 0;
  int unsigned rcv_count = 0;
  int unsigned exp_tag   = 0;
  logic [3:0]  exp_flags;
  bit          table_ready = 1'b0;

  dotp_unit_top #(
    .NUM_PIPE_REGS (NUM_PIPE_REGS),
    .TAG_WIDTH     (TAG_WIDTH)
  ) dotp_unit_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operand_c_i (operand_c),
    .tag_i       (tag_in),
    .csr_we_i    (csr_we),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .res_valid_o (res_valid),
    .result_o    (result),
    .status_o    (status),
    .tag_o       (tag_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;  // equals the edge count from the falling edge on

  // --------------------
  // helpers
  // --------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      errors++;
    end
  endtask

  task automatic add_vector(input dotp_op_pkg::dotp_op_e op_v, input logic [31:0] a_v,
                            input logic [31:0] b_v, input logic [31:0] c_v,
                            input dotp_op_pkg::round_mode_e mode_v,
                            input logic [15:0] res_v, input logic [3:0] st_v);
    vec_op.push_back(op_v);
    vec_a.push_back(a_v);
    vec_b.push_back(b_v);
    vec_c.push_back(c_v);
    vec_mode.push_back(mode_v);
    vec_res.push_back(res_v);
    vec_st.push_back(st_v);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    op_valid <= 1'b0;
    csr_we   <= 1'b0;
    csr_addr <= dotp_op_pkg::CSR_FFLAGS;  // default read view
  endtask

  task automatic write_csr(input dotp_op_pkg::csr_addr_e addr, input logic [3:0] data);
    @(posedge clk);
    op_valid  <= 1'b0;
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
  endtask

  task automatic issue_op(input int unsigned idx);
    @(posedge clk);
    op_valid   <= 1'b1;
    op         <= vec_op[idx];
    operand_a  <= vec_a[idx];
    operand_b  <= vec_b[idx];
    operand_c  <= vec_c[idx];
    tag_in     <= TAG_WIDTH'(idx);
    csr_we     <= 1'b0;
    csr_addr   <= dotp_op_pkg::CSR_FFLAGS;
    issue_edge[idx] = cyc + 1;  // cyc still holds the count before this edge
  endtask

  task automatic check_result();
    int unsigned idx;
    idx = 32'(tag_out);
    if (idx >= vec_op.size()) begin
      $display("a result arrived with tag %0d, which was never issued", idx);
      errors++;
    end else begin
      check_value("tag_o", 32'(tag_out), exp_tag);  // in order, once each
      check_value("res_valid_o latency", cyc - issue_edge[idx], LATENCY);
      check_value("result_o", result, {16'hFFFF, vec_res[idx]});
      check_value("status_o", 32'(status), 32'(vec_st[idx]));
    end
    exp_tag++;
    rcv_count++;
  endtask

  task automatic print_counts();
    $display("errors: %0d, results received: %0d of %0d", errors, rcv_count, vec_op.size());
  endtask

  task automatic finish_run();
    print_counts();
    if (errors == 0 && rcv_count == vec_op.size()) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // --------------------
  // receiver
  // --------------------
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && res_valid) begin
        check_result();
      end
    end
  end

  // --------------------
  // watchdog
  // --------------------
  initial begin
    int unsigned limit;
    wait (table_ready);
    limit = (vec_op.size() + 20) * (NUM_PIPE_REGS + 2);
    repeat (limit) @(posedge clk);
    $display("the run timed out after %0d cycles with results still missing", limit);
    print_counts();
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------
  // driver
  // --------------------
  initial begin
    dotp_op_pkg::round_mode_e cur_mode;
    void'($urandom(99875));
    rst_n     = 1'b0;
    op_valid  = 1'b0;
    op        = OP_DOT;
    operand_a = '0;
    operand_b = '0;
    operand_c = '0;
    tag_in    = '0;
    csr_we    = 1'b0;
    csr_addr  = dotp_op_pkg::CSR_FFLAGS;
    csr_wdata = '0;
    load_vectors();
    exp_flags = '0;
    foreach (vec_st[i]) exp_flags = exp_flags | vec_st[i];  // sticky OR of the whole run
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n    <= 1'b1;
    cur_mode = dotp_op_pkg::RNE;  // reset value of frm

    for (int unsigned i = 0; i < vec_op.size(); i++) begin
      if (vec_mode[i] != cur_mode) begin
        write_csr(dotp_op_pkg::CSR_FRM, {2'b00, vec_mode[i]});  // lands before the next issue
        cur_mode = vec_mode[i];
      end else if ($urandom % 4 == 0) begin
        drive_idle();  // occasional bubble
      end
      issue_op(i);
    end
    drive_idle();

    wait (rcv_count == vec_op.size());
    repeat (2) drive_idle();  // last flags retire a cycle after the result
    @(negedge clk);
    check_value("csr_rdata_o fflags", 32'(csr_rdata), 32'(exp_flags));

    @(posedge clk);
    csr_addr <= dotp_op_pkg::CSR_FRM;
    @(negedge clk);
    check_value("csr_rdata_o frm", 32'(csr_rdata), 32'({2'b00, cur_mode}));

    // clear and read back
    write_csr(dotp_op_pkg::CSR_FFLAGS, 4'b0000);
    drive_idle();
    @(negedge clk);
    check_value("csr_rdata_o fflags", 32'(csr_rdata), 32'h0);

    finish_run();
  end

`include "dotp_vectors.svh"

endmodule

`default_nettype wire
